// File: mem_burst_engine.sv
// Avalon-MM burst master
`timescale 1ns/1ps

module mem_burst_engine import mem_test_pkg::*; #(
  parameter int ADDR_WIDTH = 26
) (
  input  logic                  pClk,
  input  logic                  rst,
  input  logic                  start,
  input  mem_cmd_t              op,
  input  logic                  test_mode,
  input  logic [ADDR_WIDTH-1:0] cmd_addr,
  input  logic [DATA_W-1:0]     cmd_wdata,
  input  logic [BURST_W-1:0]    cmd_burst,
  input  logic [31:0]           test_addr,
  input  logic [DATA_W-1:0]     test_wdata,
  input  logic                  window_issued,
  // avalon-mm master
  output logic [ADDR_WIDTH-1:0] avs_address,
  output logic                  avs_write,
  output logic                  avs_read,
  output logic [DATA_W-1:0]     avs_writedata,
  output logic [DATA_W/8-1:0]   avs_byteenable,
  output logic [BURST_W-1:0]    avs_burstcount,
  input  logic                  avs_waitrequest,
  input  logic [DATA_W-1:0]     avs_readdata,
  input  logic                  avs_readdatavalid,
  output logic                  req_done,
  output logic                  rsp_done,
  output logic                  issue_accept,
  output logic                  beat_valid,
  output logic [DATA_W-1:0]     beat_data
);

  localparam int BEAT_W = $clog2(BURST_MAX_BEATS + 1);  // 11 bit beat index

  logic                  active, cur_test, rd_sent, accept;
  mem_cmd_t              cur_op;
  logic [BEAT_W-1:0]     wr_beat, rd_beat;  // both count from 1
  logic [2:0]            out_cnt;           // test reads in flight, 0..4
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_W-1:0]     wdata_q;
  logic [BURST_W-1:0]    burst_q;

  // ****************************************
  // request side
  // ****************************************
  // requests come from registered state so they hold under waitrequest
  assign avs_write = active & (cur_op == CMD_WRITE) & ~(cur_test & window_issued);
  assign avs_read  = active & (cur_op == CMD_READ) &
                     (cur_test ? (~window_issued & (out_cnt < MAX_OUTSTANDING)) : ~rd_sent);
  assign accept    = (avs_write | avs_read) & ~avs_waitrequest;

  assign avs_address    = cur_test ? test_addr[ADDR_WIDTH-1:0] : addr_q;
  assign avs_writedata  = cur_test ? test_wdata : {wr_beat, wdata_q[DATA_W-BEAT_W-1:0]};
  assign avs_burstcount = cur_test ? BURST_W'(1) : burst_q;  // test is single beat
  assign avs_byteenable = '1;

  assign issue_accept = accept & cur_test;
  assign req_done     = accept & ~cur_test & (avs_read | ({1'b0, wr_beat} == burst_q));
  assign rsp_done     = active & (cur_op == CMD_READ) & avs_readdatavalid &
                        (cur_test ? (window_issued & (out_cnt == 3'd1))
                                  : ({1'b0, rd_beat} == burst_q));
  assign beat_valid   = avs_readdatavalid;
  assign beat_data    = avs_readdata;

  always_ff @(posedge pClk) begin
    if (rst) begin
      active   <= 1'b0;
      cur_op   <= CMD_NONE;
      cur_test <= 1'b0;
      rd_sent  <= 1'b0;
      wr_beat  <= BEAT_W'(1);
      rd_beat  <= BEAT_W'(1);
      out_cnt  <= '0;
    end else begin
      if ((req_done & avs_write) | rsp_done)
        active <= 1'b0;  // test write pass stays up until the read start
      if (accept & avs_read)
        rd_sent <= 1'b1;
      if (accept & avs_write & ~cur_test)
        wr_beat <= wr_beat + 1'b1;
      if (avs_readdatavalid & active & ~cur_test)
        rd_beat <= rd_beat + 1'b1;
      // outstanding window for pipelined test reads
      case ({issue_accept & avs_read, avs_readdatavalid & cur_test})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: ;
      endcase
      if (start) begin
        active   <= 1'b1;
        cur_op   <= op;
        cur_test <= test_mode;
        rd_sent  <= 1'b0;
        wr_beat  <= BEAT_W'(1);
        rd_beat  <= BEAT_W'(1);
      end
    end
  end

  always_ff @(posedge pClk) begin
    if (start) begin  // snapshot so csr writes cannot disturb a burst
      addr_q  <= cmd_addr;
      wdata_q <= cmd_wdata;
      burst_q <= cmd_burst;
    end
  end

endmodule

// File: mem_csr_apb.sv
// APB register block
`timescale 1ns/1ps

module mem_csr_apb import mem_test_pkg::*; #(
  parameter int ADDR_WIDTH = 26
) (
  input  logic                  pClk,
  input  logic                  rst,
  // apb slave, zero wait states
  input  logic [7:0]            paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  // status from the fsm
  input  logic                  wr_done_pulse,
  input  logic                  rd_done_pulse,
  input  logic                  test_done_pulse,
  input  logic                  cmd_dropped_pulse,
  input  logic                  ready,
  input  test_state_t           state,
  input  logic                  rd_beat_valid,
  input  logic [DATA_W-1:0]     rd_beat_data,
  input  logic [7:0]            err_count,
  // command side
  output logic                  cmd_valid,
  output mem_cmd_t              cmd_op,
  output logic                  status_clear,
  output logic [ADDR_WIDTH-1:0] cmd_addr,
  output logic [DATA_W-1:0]     cmd_wdata,
  output logic [BURST_W-1:0]    cmd_burst
);

  logic              access, wr_en;
  logic              mapped, read_only;
  logic              wr_done, rd_done, test_done, cmd_dropped;  // sticky bits
  logic [DATA_W-1:0] rdata_q;                                   // last read beat
  logic [31:0]       status;

  // zero means one beat, anything above the beat index range saturates
  function automatic logic [BURST_W-1:0] burst_clamp(input logic [31:0] v);
    if (v == 32'd0)
      return BURST_W'(1);
    if (v > BURST_MAX_BEATS)
      return BURST_W'(BURST_MAX_BEATS);
    return v[BURST_W-1:0];
  endfunction

  assign access = psel & penable;  // access phase, transfer ends here
  assign wr_en  = access & pwrite;
  assign pready = 1'b1;

  // ****************************************
  // address decode
  // ****************************************
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    case (paddr)
      CSR_CTRL, CSR_ADDR, CSR_WDATA_LO, CSR_WDATA_HI, CSR_BURST: ;
      CSR_RDATA_LO, CSR_RDATA_HI, CSR_STATUS: read_only = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign pslverr = access & (~mapped | (pwrite & read_only));

  // CTRL write launches a command, opcode zero only clears
  assign cmd_op       = mem_cmd_t'(pwdata[1:0]);
  assign cmd_valid    = wr_en & (paddr == CSR_CTRL) & (cmd_op != CMD_NONE);
  assign status_clear = wr_en & (paddr == CSR_CTRL) & pwdata[4];

  always_ff @(posedge pClk) begin
    if (wr_en) begin
      case (paddr)
        CSR_ADDR:     cmd_addr         <= pwdata[ADDR_WIDTH-1:0];
        CSR_WDATA_LO: cmd_wdata[31:0]  <= pwdata;
        CSR_WDATA_HI: cmd_wdata[63:32] <= pwdata;
        CSR_BURST:    cmd_burst        <= burst_clamp(pwdata);
        default: ;
      endcase
    end
    if (rd_beat_valid)
      rdata_q <= rd_beat_data;  // keeps the latest beat
  end

  // ****************************************
  // sticky status
  // ****************************************
  always_ff @(posedge pClk) begin
    if (rst) begin
      wr_done     <= 1'b0;
      rd_done     <= 1'b0;
      test_done   <= 1'b0;
      cmd_dropped <= 1'b0;
    end else begin
      if (status_clear) begin
        wr_done     <= 1'b0;
        rd_done     <= 1'b0;
        test_done   <= 1'b0;
        cmd_dropped <= 1'b0;
      end
      // a new event wins over a clear in the same cycle
      if (wr_done_pulse)     wr_done     <= 1'b1;
      if (rd_done_pulse)     rd_done     <= 1'b1;
      if (test_done_pulse)   test_done   <= 1'b1;
      if (cmd_dropped_pulse) cmd_dropped <= 1'b1;
    end
  end

  // pass bit follows the live error count
  assign status = {13'd0, state, err_count, 2'b00, cmd_dropped, ready,
                   test_done & (err_count == 8'd0), test_done, rd_done, wr_done};

  always_comb begin
    case (paddr)
      CSR_ADDR:     prdata = 32'(cmd_addr);
      CSR_WDATA_LO: prdata = cmd_wdata[31:0];
      CSR_WDATA_HI: prdata = cmd_wdata[63:32];
      CSR_BURST:    prdata = 32'(cmd_burst);
      CSR_RDATA_LO: prdata = rdata_q[31:0];
      CSR_RDATA_HI: prdata = rdata_q[63:32];
      CSR_STATUS:   prdata = status;
      default:      prdata = 32'd0;  // CTRL and holes read zero
    endcase
  end

endmodule

// File: mem_pattern_check.sv
// Address test pattern and compare
`timescale 1ns/1ps

module mem_pattern_check import mem_test_pkg::*; #(
  parameter int TEST_ADDR_BITS = 6
) (
  input  logic              pClk,
  input  logic              rst,
  input  logic              test_mode,
  input  logic              start,
  input  logic              issue_accept,
  input  logic              beat_valid,
  input  logic [DATA_W-1:0] beat_data,
  output logic [31:0]       test_addr,
  output logic [DATA_W-1:0] test_wdata,
  output logic              window_issued,
  output logic              window_checked,
  output logic [7:0]        err_count
);

  logic [TEST_ADDR_BITS:0]   issue_cnt;   // top bit set once all issued
  logic [TEST_ADDR_BITS-1:0] chk_cnt;     // next address to compare
  logic                      in_wr_phase; // toggles on each test start
  logic [DATA_W-1:0]         chk_expect;
  logic                      mismatch;

  // inverted address on top, address below
  function automatic logic [DATA_W-1:0] pattern(input logic [31:0] a);
    return {~a, a};
  endfunction

  assign test_addr     = 32'(issue_cnt[TEST_ADDR_BITS-1:0]);
  assign test_wdata    = pattern(test_addr);
  assign window_issued = issue_cnt[TEST_ADDR_BITS];

  // ****************************************
  // return compare
  // ****************************************
  // memory returns in order, so a plain counter tracks the address
  assign chk_expect     = pattern(32'(chk_cnt));
  assign mismatch       = test_mode & beat_valid & (beat_data != chk_expect);
  assign window_checked = test_mode & beat_valid & (&chk_cnt);  // last compare

  always_ff @(posedge pClk) begin
    if (rst) begin
      issue_cnt   <= '0;
      chk_cnt     <= '0;
      err_count   <= '0;
      in_wr_phase <= 1'b0;
    end else begin
      if (issue_accept)
        issue_cnt <= issue_cnt + 1'b1;
      if (test_mode & beat_valid)
        chk_cnt <= chk_cnt + 1'b1;
      if (mismatch && err_count != 8'hFF)
        err_count <= err_count + 1'b1;  // saturates
      if (start & test_mode) begin
        issue_cnt   <= '0;  // both passes walk the window from zero
        in_wr_phase <= ~in_wr_phase;
        if (!in_wr_phase) begin  // write pass start, fresh test
          chk_cnt   <= '0;
          err_count <= '0;
        end
      end
    end
  end

endmodule

// File: mem_test_checker.sv
// Avalon master protocol checks
`timescale 1ns/1ps

module mem_test_checker import mem_test_pkg::*; #(
  parameter int ADDR_WIDTH = 26
) (
  input logic                  pClk,
  input logic                  rst,
  input logic [ADDR_WIDTH-1:0] avs_address,
  input logic                  avs_write,
  input logic                  avs_read,
  input logic [DATA_W-1:0]     avs_writedata,
  input logic [BURST_W-1:0]    avs_burstcount,
  input logic                  avs_waitrequest,
  input logic [2:0]            out_cnt          // engine's test reads in flight
);

  // ****************************************
  // request held while the slave stalls
  // ****************************************
  property hold_under_wait;
    @(posedge pClk) disable iff (rst)
      (avs_write || avs_read) && avs_waitrequest |=>
        $stable(avs_address) && $stable(avs_burstcount) && $stable(avs_writedata) &&
        $stable(avs_write) && $stable(avs_read);
  endproperty

  assert property (hold_under_wait)
    else $error("avalon request changed under waitrequest");

  assert property (@(posedge pClk) disable iff (rst) out_cnt <= 3'(MAX_OUTSTANDING))
    else $error("outstanding reads above limit: %0d", out_cnt);

  assert property (@(posedge pClk) disable iff (rst) !(avs_write && avs_read))
    else $error("avs_write and avs_read both high");

endmodule

bind mem_burst_engine mem_test_checker #(.ADDR_WIDTH(ADDR_WIDTH)) mem_test_checker_inst (
  .pClk(pClk), .rst(rst),
  .avs_address(avs_address), .avs_write(avs_write), .avs_read(avs_read),
  .avs_writedata(avs_writedata),
  .avs_burstcount(avs_burstcount), .avs_waitrequest(avs_waitrequest),
  .out_cnt(out_cnt)
);

// File: mem_test_ctrl.sv
// Memory test control FSM
`timescale 1ns/1ps

module mem_test_ctrl import mem_test_pkg::*; (
  input  logic        pClk,
  input  logic        rst,
  input  logic        cmd_valid,
  input  mem_cmd_t    cmd_op,
  input  logic        req_done,        // last request accepted
  input  logic        rsp_done,        // last read beat back
  input  logic        window_issued,
  input  logic        window_checked,
  output logic        start,
  output mem_cmd_t    op,
  output logic        test_mode,
  output logic        ready,
  output test_state_t state,
  output logic        wr_done_pulse,
  output logic        rd_done_pulse,
  output logic        test_done_pulse,
  output logic        cmd_dropped_pulse
);

  // ****************************************
  // state register
  // ****************************************
  always_ff @(posedge pClk) begin
    if (rst) begin
      state <= ST_IDLE;
      start <= 1'b0;
      op    <= CMD_NONE;
      ready <= 1'b0;  // rises on the first cycle out of reset
    end else begin
      start <= 1'b0;  // single cycle strobe
      case (state)
        ST_IDLE: begin
          ready <= 1'b1;
          if (cmd_valid && cmd_op != CMD_NONE) begin
            start <= 1'b1;
            op    <= cmd_op;
            ready <= 1'b0;
            case (cmd_op)
              CMD_WRITE: state <= ST_WR_REQ;
              CMD_READ:  state <= ST_RD_REQ;
              default: begin
                state <= ST_TEST_WRITE;
                op    <= CMD_WRITE;  // test starts with the write pass
              end
            endcase
          end
        end

        ST_WR_REQ:
          if (req_done)
            state <= ST_WR_RSP;

        ST_WR_RSP: begin  // posted write, nothing to wait for
          state <= ST_IDLE;
          ready <= 1'b1;
        end

        ST_RD_REQ:
          if (req_done)
            state <= ST_RD_RSP;

        ST_RD_RSP:
          if (rsp_done) begin
            state <= ST_IDLE;
            ready <= 1'b1;
          end

        ST_TEST_WRITE:
          // issue count from the last test is still up while start is high
          if (window_issued && !start) begin
            state <= ST_TEST_READ;
            start <= 1'b1;
            op    <= CMD_READ;
          end

        ST_TEST_READ:
          // engine drained and checker saw the whole window
          if (rsp_done && window_checked) begin
            state <= ST_IDLE;
            ready <= 1'b1;
          end

        default: state <= ST_IDLE;
      endcase
    end
  end

  // ****************************************
  // decoded outputs
  // ****************************************
  assign test_mode         = (state == ST_TEST_WRITE) || (state == ST_TEST_READ);
  assign wr_done_pulse     = (state == ST_WR_RSP);
  assign rd_done_pulse     = (state == ST_RD_RSP) && rsp_done;
  assign test_done_pulse   = (state == ST_TEST_READ) && rsp_done && window_checked;
  assign cmd_dropped_pulse = cmd_valid && (state != ST_IDLE);  // busy, command lost

endmodule

// File: mem_test_pkg.sv
// Memory test engine shared definitions

package mem_test_pkg;

  // ****************************************
  // bus widths and limits
  // ****************************************
  localparam int DATA_W          = 64;    // avalon data bus
  localparam int BURST_W         = 12;    // avalon burstcount width
  localparam int BURST_MAX_BEATS = 2047;  // fits the 11 bit beat index
  localparam int MAX_OUTSTANDING = 4;     // test reads in flight

  // control fsm states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_TEST_WRITE,
    ST_TEST_READ,
    ST_RD_REQ,
    ST_RD_RSP,
    ST_WR_REQ,
    ST_WR_RSP
  } test_state_t;

  // opcode field of the CTRL register
  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_WRITE,
    CMD_READ,
    CMD_ADDR_TEST
  } mem_cmd_t;

  // ****************************************
  // csr byte offsets
  // ****************************************
  localparam logic [7:0] CSR_CTRL     = 8'h00;  // op in [1:0], clear in [4]
  localparam logic [7:0] CSR_ADDR     = 8'h04;
  localparam logic [7:0] CSR_WDATA_LO = 8'h08;
  localparam logic [7:0] CSR_WDATA_HI = 8'h0C;
  localparam logic [7:0] CSR_BURST    = 8'h10;
  localparam logic [7:0] CSR_RDATA_LO = 8'h14;  // read only
  localparam logic [7:0] CSR_RDATA_HI = 8'h18;  // read only
  localparam logic [7:0] CSR_STATUS   = 8'h1C;  // read only

endpackage

// File: mem_test_tb.sv
// Memory test engine testbench
`timescale 1ns/1ps

module mem_test_tb import mem_test_pkg::*;;

  localparam int ADDR_WIDTH = 26;
  localparam int POLL_LIMIT = 2000;  // status reads before giving up

  logic                  pClk, rst;
  logic [7:0]            paddr;
  logic                  psel, penable, pwrite, pready, pslverr;
  logic [31:0]           pwdata, prdata;
  logic [ADDR_WIDTH-1:0] avs_address;
  logic                  avs_write, avs_read, avs_waitrequest, avs_readdatavalid;
  logic [DATA_W-1:0]     avs_writedata, avs_readdata;
  logic [DATA_W/8-1:0]   avs_byteenable;
  logic [BURST_W-1:0]    avs_burstcount;

  logic [63:0] mem [0:255];          // slave memory, low 8 address bits
  logic [7:0]  rd_q[$];              // addresses of read beats still owed
  logic [7:0]  wr_base, ret_addr;
  int          wr_left, wr_idx;
  logic        corrupt_en;           // flips bit 0 on the two bad addresses
  logic [15:0] lfsr_q = 16'd3;
  int          checks, errors, test_errs;

  mem_test_top #(.ADDR_WIDTH(ADDR_WIDTH), .TEST_ADDR_BITS(6)) mem_test_top_inst (.*);

  initial begin
    pClk = 1'b0;
    forever #4 pClk = ~pClk;  // 8 ns period
  end

  // ****************************************
  // reference model and helpers
  // ****************************************
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic take_rand_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  // beat number in the top 11 bits, wdata below
  function automatic logic [63:0] beat_word(input logic [63:0] wd, input int beat);
    return {11'(beat), wd[52:0]};
  endfunction

  function automatic logic [63:0] test_pattern(input int a);
    return {~32'(a), 32'(a)};
  endfunction

  // idle engine assumed, so ready set and state ST_IDLE
  function automatic logic [31:0] exp_status(input logic wr, rd, tst, dropped,
                                             input logic [7:0] errs);
    logic [31:0] s;
    s        = '0;
    s[0]     = wr;
    s[1]     = rd;
    s[2]     = tst;
    s[3]     = tst && (errs == 8'd0);
    s[4]     = 1'b1;
    s[5]     = dropped;
    s[15:8]  = errs;
    s[18:16] = 3'(ST_IDLE);
    return s;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d mismatches", name, test_errs);
    test_errs = 0;
  endtask

  // ****************************************
  // apb master
  // ****************************************
  task automatic apb_xfer(input logic [7:0] a, input logic wr, input logic [31:0] d,
                          output logic [31:0] rd, output logic err);
    @(posedge pClk);
    #1;                 // setup
    paddr   = a;
    pwrite  = wr;
    pwdata  = d;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge pClk);
    #1 penable = 1'b1;  // access
    @(negedge pClk);
    rd  = prdata;   // mid access phase, no wait states
    err = pslverr;
    check_value("pready", 64'(pready), 64'd1);
    @(posedge pClk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
    logic [31:0] unused;
    apb_xfer(a, 1'b1, d, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
    apb_xfer(a, 1'b0, 32'd0, d, err);
  endtask

  task automatic wait_status(input int bit_idx, input string what);
    logic [31:0] s;
    logic        err;
    int          polls;
    s     = '0;
    polls = 0;
    while (!s[bit_idx] && polls < POLL_LIMIT) begin
      apb_read(CSR_STATUS, s, err);
      polls++;
    end
    if (!s[bit_idx]) begin
      $display("timeout waiting for %s after %0d status reads", what, polls);
      $display("Test failed");
      $finish;
    end
  endtask

  // ****************************************
  // avalon slave model
  // ****************************************
  always @(negedge pClk) begin  // requests are settled mid cycle
    if (!rst && !avs_waitrequest) begin
      if (avs_write || avs_read)
        check_value("avs_byteenable", 64'(avs_byteenable), 64'hFF);  // no byte masking
      if (avs_write) begin
        if (wr_left == 0) begin  // first beat of a burst
          wr_base = avs_address[7:0];
          wr_left = int'(avs_burstcount);
          wr_idx  = 0;
        end
        mem[8'(int'(wr_base) + wr_idx)] = avs_writedata;
        wr_idx++;
        wr_left--;
      end else if (avs_read) begin
        for (int i = 0; i < int'(avs_burstcount); i++)
          rd_q.push_back(8'(int'(avs_address[7:0]) + i));
      end
    end
  end

  always @(posedge pClk) begin
    #1;
    if (rst) begin
      avs_waitrequest   = 1'b1;
      avs_readdatavalid = 1'b0;
    end else begin
      avs_waitrequest   = take_rand_bit();
      avs_readdatavalid = 1'b0;
      if (rd_q.size() > 0) begin
        if (take_rand_bit()) begin  // random return delay, order kept
          ret_addr          = rd_q.pop_front();
          avs_readdata      = mem[ret_addr] ^
                              64'(corrupt_en && (ret_addr == 8'd5 || ret_addr == 8'd42));
          avs_readdatavalid = 1'b1;
        end
      end
    end
  end

  // ****************************************
  // test sequence
  // ****************************************
  initial begin
    logic [31:0] s, lo, hi;
    logic        err;
    logic [7:0]  a_base;
    logic [63:0] wd;
    rst               = 1'b1;
    paddr             = '0;
    psel              = 1'b0;
    penable           = 1'b0;
    pwrite            = 1'b0;
    pwdata            = '0;
    avs_waitrequest   = 1'b1;
    avs_readdatavalid = 1'b0;
    avs_readdata      = '0;
    corrupt_en        = 1'b0;
    wr_left           = 0;
    wr_idx            = 0;
    wr_base           = '0;
    checks            = 0;
    errors            = 0;
    test_errs         = 0;
    a_base = 8'h80;                    // outside the 64 word test window
    wd     = 64'h0123_4567_89AB_CDEF;
    for (int k = 0; k < 256; k++)
      mem[k] = {32'(k) ^ 32'hA5A5_A5A5, 32'(k) ^ 32'h5A5A_5A5A};
    repeat (5) @(posedge pClk);
    #1 rst = 1'b0;
    repeat (3) @(posedge pClk);

    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(0, 0, 0, 0, 8'd0));
    end_test("test 1 reset status");

    apb_write(CSR_ADDR, 32'(a_base), err);
    apb_write(CSR_WDATA_LO, wd[31:0], err);
    apb_write(CSR_WDATA_HI, wd[63:32], err);
    apb_write(CSR_BURST, 32'd4, err);
    apb_write(CSR_CTRL, 32'(CMD_WRITE), err);
    check_value("pslverr", 64'(err), 64'd0);
    wait_status(0, "write burst done");
    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(1, 0, 0, 0, 8'd0));
    for (int i = 0; i < 4; i++)
      check_value($sformatf("mem[%0d]", a_base + i), mem[8'(a_base + i)], beat_word(wd, i + 1));
    end_test("test 2 write burst");

    apb_write(CSR_CTRL, 32'(CMD_READ), err);
    wait_status(1, "read burst done");
    apb_read(CSR_RDATA_LO, lo, err);
    apb_read(CSR_RDATA_HI, hi, err);
    check_value("rdata", {hi, lo}, beat_word(wd, 4));  // last beat kept
    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(1, 1, 0, 0, 8'd0));
    end_test("test 3 read burst");

    apb_write(CSR_CTRL, 32'(CMD_ADDR_TEST), err);
    wait_status(2, "address test done");
    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(1, 1, 1, 0, 8'd0));
    for (int a = 0; a < 64; a++)
      check_value($sformatf("mem[%0d]", a), mem[a], test_pattern(a));
    end_test("test 4 address test");

    apb_write(CSR_CTRL, 32'h10, err);  // clear sticky bits only
    corrupt_en = 1'b1;
    apb_write(CSR_CTRL, 32'(CMD_ADDR_TEST), err);
    wait_status(2, "address test with corruption done");
    corrupt_en = 1'b0;
    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(0, 0, 1, 0, 8'd2));
    end_test("test 5 corrupted read back");

    apb_write(CSR_CTRL, 32'h10, err);
    apb_write(CSR_CTRL, 32'(CMD_ADDR_TEST), err);
    apb_write(CSR_CTRL, 32'(CMD_READ), err);  // engine still busy
    check_value("pslverr", 64'(err), 64'd0);
    apb_read(8'h20, s, err);                   // hole in the map
    check_value("pslverr", 64'(err), 64'd1);
    apb_write(CSR_STATUS, 32'hFFFF_FFFF, err); // read only
    check_value("pslverr", 64'(err), 64'd1);
    wait_status(2, "address test after drop done");
    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(0, 0, 1, 1, 8'd0));
    apb_write(CSR_CTRL, 32'h10, err);
    apb_read(CSR_STATUS, s, err);
    check_value("status", s, exp_status(0, 0, 0, 0, 8'd0));
    end_test("test 6 drop, slverr, clear");

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: mem_test_top.sv
// Memory test engine top level
`timescale 1ns/1ps

module mem_test_top import mem_test_pkg::*; #(
  parameter int ADDR_WIDTH     = 26,
  parameter int TEST_ADDR_BITS = 6
) (
  input  logic                  pClk,
  input  logic                  rst,
  // apb
  input  logic [7:0]            paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  // avalon-mm
  output logic [ADDR_WIDTH-1:0] avs_address,
  output logic                  avs_write,
  output logic                  avs_read,
  output logic [DATA_W-1:0]     avs_writedata,
  output logic [DATA_W/8-1:0]   avs_byteenable,
  output logic [BURST_W-1:0]    avs_burstcount,
  input  logic                  avs_waitrequest,
  input  logic [DATA_W-1:0]     avs_readdata,
  input  logic                  avs_readdatavalid
);

  // ****************************************
  // internal nets
  // ****************************************
  logic                  cmd_valid, start, test_mode, ready;
  mem_cmd_t              cmd_op, op;
  test_state_t           state;
  logic                  wr_done_pulse, rd_done_pulse, test_done_pulse, cmd_dropped_pulse;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_W-1:0]     cmd_wdata, test_wdata, beat_data;
  logic [BURST_W-1:0]    cmd_burst;
  logic [31:0]           test_addr;
  logic                  req_done, rsp_done, issue_accept, beat_valid;
  logic                  window_issued, window_checked;
  logic [7:0]            err_count;

  mem_csr_apb #(.ADDR_WIDTH(ADDR_WIDTH)) mem_csr_apb_inst (
    .pClk(pClk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .wr_done_pulse(wr_done_pulse), .rd_done_pulse(rd_done_pulse),
    .test_done_pulse(test_done_pulse), .cmd_dropped_pulse(cmd_dropped_pulse),
    .ready(ready), .state(state),
    .rd_beat_valid(beat_valid), .rd_beat_data(beat_data), .err_count(err_count),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .status_clear(),  // sticky clear is handled inside the csr block
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .cmd_burst(cmd_burst)
  );

  mem_test_ctrl mem_test_ctrl_inst (
    .pClk(pClk), .rst(rst),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .req_done(req_done), .rsp_done(rsp_done),
    .window_issued(window_issued), .window_checked(window_checked),
    .start(start), .op(op), .test_mode(test_mode), .ready(ready), .state(state),
    .wr_done_pulse(wr_done_pulse), .rd_done_pulse(rd_done_pulse),
    .test_done_pulse(test_done_pulse), .cmd_dropped_pulse(cmd_dropped_pulse)
  );

  mem_burst_engine #(.ADDR_WIDTH(ADDR_WIDTH)) mem_burst_engine_inst (
    .pClk(pClk), .rst(rst),
    .start(start), .op(op), .test_mode(test_mode),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .cmd_burst(cmd_burst),
    .test_addr(test_addr), .test_wdata(test_wdata), .window_issued(window_issued),
    .avs_address(avs_address), .avs_write(avs_write), .avs_read(avs_read),
    .avs_writedata(avs_writedata), .avs_byteenable(avs_byteenable),
    .avs_burstcount(avs_burstcount), .avs_waitrequest(avs_waitrequest),
    .avs_readdata(avs_readdata), .avs_readdatavalid(avs_readdatavalid),
    .req_done(req_done), .rsp_done(rsp_done), .issue_accept(issue_accept),
    .beat_valid(beat_valid), .beat_data(beat_data)
  );

  mem_pattern_check #(.TEST_ADDR_BITS(TEST_ADDR_BITS)) mem_pattern_check_inst (
    .pClk(pClk), .rst(rst),
    .test_mode(test_mode), .start(start),
    .issue_accept(issue_accept), .beat_valid(beat_valid), .beat_data(beat_data),
    .test_addr(test_addr), .test_wdata(test_wdata),
    .window_issued(window_issued), .window_checked(window_checked),
    .err_count(err_count)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the memory test engine simulation with Verilator.
# Exit status is zero only when the run log holds no failure report.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_test_tb -f sim.f -o mem_test_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build did not complete, see $BUILD_LOG"
  exit 1
fi

./obj_dir/mem_test_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  exit 1
fi
exit 0

// File: sim.f
mem_test_pkg.sv
mem_csr_apb.sv
mem_test_ctrl.sv
mem_burst_engine.sv
mem_pattern_check.sv
mem_test_top.sv
mem_test_checker.sv
mem_test_tb.sv
